/* src/load_unit_pkg.sv */
/*
 * load unit shared definitions
 * widths of the data cache port, the load operator and issue state encodings,
 * and the packed bundles passed between the load queue, the issue FSM,
 * the result aligner and the data cache
 */
`default_nettype none

package load_unit_pkg;

    // ------------------------------------------------------------------------
    // widths and constants
    // ------------------------------------------------------------------------

    // data and address width of the core
    parameter int unsigned XLEN               = 64;
    parameter int unsigned TRANS_ID_BITS      = 3;
    // the index is taken from the untranslated part of the virtual address
    parameter int unsigned DCACHE_INDEX_WIDTH = 12;
    parameter int unsigned DCACHE_TAG_WIDTH   = 44;
    parameter int unsigned PAGE_OFFSET_BITS   = 12;
    // the control CSR has to hold this value for the window to take effect
    parameter logic [XLEN-1:0] APPROX_ENABLE_KEY = 64'hA;

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------

    // signed and unsigned forms of each size sit next to each other
    typedef enum logic [2:0] {
        LD, LW, LWU, LH, LHU, LB, LBU
    } load_op_e;

    typedef enum logic [2:0] {
        IDLE, WAIT_PAGE_OFFSET, WAIT_GNT, SEND_TAG,
        ABORT_TRANSACTION, WAIT_TRANSLATION, WAIT_FLUSH
    } load_state_e;

    // ------------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------------

    // one entry of the load queue
    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          vaddr;
        load_op_e                 op;
        logic [XLEN/8-1:0]        be;
    } load_req_t;

    // approximation window, both bounds are inclusive
    typedef struct packed {
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] limit;
        logic [XLEN-1:0] key;
    } approx_csr_t;

    // request towards the data cache, the tag follows the index by one cycle
    typedef struct packed {
        logic [DCACHE_INDEX_WIDTH-1:0] address_index;
        logic [DCACHE_TAG_WIDTH-1:0]   address_tag;
        logic                          data_req;
        logic                          kill_req;
        logic                          tag_valid;
        logic [1:0]                    data_size;
        logic [XLEN/8-1:0]             data_be;
        logic                          approx;
    } dcache_req_t;

    typedef struct packed {
        logic            data_gnt;
        logic            data_rvalid;
        logic [XLEN-1:0] data_rdata;
    } dcache_rsp_t;

    // what the result path needs to know about the load in flight
    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [2:0]               addr_offset;
        load_op_e                 op;
    } load_info_t;

endpackage

`default_nettype wire

/* src/load_issue_fsm.sv */
/*
 * load issue FSM
 * takes one load at a time from the load queue, sends the cache index while
 * the address is being translated and the physical tag one cycle after the
 * grant, waits out page-offset conflicts with pending stores, retries after
 * a TLB miss and kills the outstanding request on a flush
 */
`timescale 1ns/100ps
`default_nettype none

module load_issue_fsm (
    input  wire                                   clk_i,
    input  wire                                   rst_ni,
    input  wire                                   flush_i,
    // load queue
    input  wire                                   valid_i,
    input  wire load_unit_pkg::load_req_t         load_req_i,
    output logic                                  pop_ld_o,
    // MMU
    output logic                                  translation_req_o,
    output logic [load_unit_pkg::XLEN-1:0]        vaddr_o,
    input  wire  [load_unit_pkg::XLEN-1:0]        paddr_i,
    input  wire                                   dtlb_hit_i,
    // store buffer address check
    output logic [load_unit_pkg::PAGE_OFFSET_BITS-1:0] page_offset_o,
    input  wire                                   page_offset_matches_i,
    input  wire load_unit_pkg::approx_csr_t       approx_csr_i,
    // data cache
    output load_unit_pkg::dcache_req_t            dcache_req_o,
    input  wire load_unit_pkg::dcache_rsp_t       dcache_rsp_i,
    // towards the result path
    output load_unit_pkg::load_info_t             load_info_o,
    output logic                                  in_flush_o,
    output logic                                  kill_o
);

    load_unit_pkg::load_state_e state_d, state_q;
    load_unit_pkg::load_state_e issue_state;
    load_unit_pkg::load_state_e gnt_state;
    load_unit_pkg::load_info_t  info_q;
    logic                       issue_trans_req;
    logic                       issue_data_req;
    logic                       issue_pop;
    logic                       data_req;
    logic                       kill_req;
    logic                       tag_valid;
    logic                       in_window;

    // the cache encodes the access size as log2 of the byte count
    function automatic logic [1:0] transfer_size(input load_unit_pkg::load_op_e op);
        logic [1:0] size;
        unique case (op)
            load_unit_pkg::LW, load_unit_pkg::LWU: size = 2'b10;
            load_unit_pkg::LH, load_unit_pkg::LHU: size = 2'b01;
            load_unit_pkg::LB, load_unit_pkg::LBU: size = 2'b00;
            default:                               size = 2'b11;
        endcase
        return size;
    endfunction

    // the MMU and the store buffer see the queue head directly
    assign vaddr_o       = load_req_i.vaddr;
    assign page_offset_o = load_req_i.vaddr[load_unit_pkg::PAGE_OFFSET_BITS-1:0];

    // a zero address never counts as approximate, even inside the window
    assign in_window = (load_req_i.vaddr != '0)
                    && (load_req_i.vaddr >= approx_csr_i.base)
                    && (load_req_i.vaddr <= approx_csr_i.limit)
                    && (approx_csr_i.key == load_unit_pkg::APPROX_ENABLE_KEY);

    // a granted request sends its tag next unless the TLB missed
    assign gnt_state = dtlb_hit_i ? load_unit_pkg::SEND_TAG : load_unit_pkg::ABORT_TRANSACTION;

    // ------------------------------------------------------------------------
    // new request, shared by IDLE and the tag cycle of the previous load
    // ------------------------------------------------------------------------
    always_comb begin : new_request
        issue_state     = load_unit_pkg::IDLE;
        issue_trans_req = 1'b0;
        issue_data_req  = 1'b0;
        issue_pop       = 1'b0;
        if (valid_i) begin
            // translation starts before the store check has settled, this eases timing
            issue_trans_req = 1'b1;
            if (page_offset_matches_i) begin
                issue_state = load_unit_pkg::WAIT_PAGE_OFFSET;
            end else begin
                issue_data_req = 1'b1;
                if (dcache_rsp_i.data_gnt) begin
                    issue_state = gnt_state;
                    issue_pop   = dtlb_hit_i;
                end else begin
                    issue_state = load_unit_pkg::WAIT_GNT;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // load control
    // ------------------------------------------------------------------------
    always_comb begin : load_control
        state_d           = state_q;
        translation_req_o = 1'b0;
        pop_ld_o          = 1'b0;
        data_req          = 1'b0;
        kill_req          = 1'b0;
        tag_valid         = 1'b0;
        unique case (state_q)
            load_unit_pkg::IDLE: begin
                state_d           = issue_state;
                translation_req_o = issue_trans_req;
                data_req          = issue_data_req;
                pop_ld_o          = issue_pop;
            end
            // the request stays down until the conflicting store has drained
            load_unit_pkg::WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = load_unit_pkg::WAIT_GNT;
                end
            end
            load_unit_pkg::WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req          = 1'b1;
                if (dcache_rsp_i.data_gnt) begin
                    state_d  = gnt_state;
                    pop_ld_o = dtlb_hit_i;
                end
            end
            // the tag from last cycle's translation goes out, the next load may be granted
            load_unit_pkg::SEND_TAG: begin
                tag_valid         = 1'b1;
                state_d           = issue_state;
                translation_req_o = issue_trans_req;
                data_req          = issue_data_req;
                pop_ld_o          = issue_pop;
            end
            // free the cache arbiter so the page table walker can serve the miss
            load_unit_pkg::ABORT_TRANSACTION: begin
                kill_req  = 1'b1;
                tag_valid = 1'b1;
                state_d   = load_unit_pkg::WAIT_TRANSLATION;
            end
            load_unit_pkg::WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = load_unit_pkg::WAIT_GNT;
                end
            end
            // the cache only acts on this kill if a request is outstanding
            load_unit_pkg::WAIT_FLUSH: begin
                kill_req  = 1'b1;
                tag_valid = 1'b1;
                state_d   = load_unit_pkg::IDLE;
            end
            default: begin
                state_d = load_unit_pkg::IDLE;
            end
        endcase
        if (flush_i) begin
            state_d = load_unit_pkg::WAIT_FLUSH;
        end
    end

    always_comb begin : compose_req
        dcache_req_o.address_index = load_req_i.vaddr[load_unit_pkg::DCACHE_INDEX_WIDTH-1:0];
        // paddr_i belongs to the load granted last cycle, it is valid in the tag cycle
        dcache_req_o.address_tag   = paddr_i[load_unit_pkg::DCACHE_TAG_WIDTH +
                                             load_unit_pkg::DCACHE_INDEX_WIDTH - 1 :
                                             load_unit_pkg::DCACHE_INDEX_WIDTH];
        dcache_req_o.data_req      = data_req;
        dcache_req_o.kill_req      = kill_req;
        dcache_req_o.tag_valid     = tag_valid;
        dcache_req_o.data_size     = transfer_size(load_req_i.op);
        dcache_req_o.data_be       = load_req_i.be;
        dcache_req_o.approx        = in_window;
    end

    assign kill_o      = kill_req;
    assign in_flush_o  = (state_q == load_unit_pkg::WAIT_FLUSH);
    assign load_info_o = info_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
        if (!rst_ni) begin
            state_q <= load_unit_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // only the most recent accepted load is kept
    always_ff @(posedge clk_i) begin : info_reg
        if (pop_ld_o) begin
            info_q.trans_id    <= load_req_i.trans_id;
            info_q.addr_offset <= load_req_i.vaddr[2:0];
            info_q.op          <= load_req_i.op;
        end
    end

endmodule

`default_nettype wire

/* src/load_result_align.sv */
/*
 * load result aligner
 * moves the addressed bytes of the returned cache word down to bit 0,
 * extends them as the load operator asks and retires the load with its
 * transaction id
 */
`timescale 1ns/100ps
`default_nettype none

module load_result_align (
    input  wire load_unit_pkg::load_info_t              load_info_i,
    input  wire load_unit_pkg::dcache_rsp_t             dcache_rsp_i,
    input  wire                                         in_flush_i,
    input  wire                                         kill_i,
    output logic                                        valid_o,
    output logic [load_unit_pkg::TRANS_ID_BITS-1:0]     trans_id_o,
    output logic [load_unit_pkg::XLEN-1:0]              result_o
);

    logic [load_unit_pkg::XLEN-1:0] shifted_data;

    // ------------------------------------------------------------------------
    // retire
    // ------------------------------------------------------------------------

    // data that returns while the request is being killed or flushed is dropped
    assign valid_o    = dcache_rsp_i.data_rvalid && !in_flush_i && !kill_i;
    assign trans_id_o = load_info_i.trans_id;

    // ------------------------------------------------------------------------
    // realign and extend
    // ------------------------------------------------------------------------

    // rdata is the aligned double word, the byte offset selects the lane
    assign shifted_data = dcache_rsp_i.data_rdata >> {load_info_i.addr_offset, 3'b000};

    always_comb begin : result_mux
        unique case (load_info_i.op)
            load_unit_pkg::LW: begin
                result_o = {{32{shifted_data[31]}}, shifted_data[31:0]};
            end
            load_unit_pkg::LWU: begin
                result_o = {32'b0, shifted_data[31:0]};
            end
            load_unit_pkg::LH: begin
                result_o = {{48{shifted_data[15]}}, shifted_data[15:0]};
            end
            load_unit_pkg::LHU: begin
                result_o = {48'b0, shifted_data[15:0]};
            end
            load_unit_pkg::LB: begin
                result_o = {{56{shifted_data[7]}}, shifted_data[7:0]};
            end
            load_unit_pkg::LBU: begin
                result_o = {56'b0, shifted_data[7:0]};
            end
            // a double word needs no extension
            default: begin
                result_o = shifted_data;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/load_unit.sv */
/*
 * load unit
 * data cache load port of a 64-bit in-order core, a request path that
 * talks to the load queue, the MMU, the store buffer and the cache,
 * followed by a result path towards writeback
 */
`timescale 1ns/100ps
`default_nettype none

module load_unit (
    input  wire                                         clk_i,
    input  wire                                         rst_ni,
    input  wire                                         flush_i,
    // load queue
    input  wire                                         valid_i,
    input  wire load_unit_pkg::load_req_t               load_req_i,
    output logic                                        pop_ld_o,
    // writeback
    output logic                                        valid_o,
    output logic [load_unit_pkg::TRANS_ID_BITS-1:0]     trans_id_o,
    output logic [load_unit_pkg::XLEN-1:0]              result_o,
    // MMU
    output logic                                        translation_req_o,
    output logic [load_unit_pkg::XLEN-1:0]              vaddr_o,
    input  wire  [load_unit_pkg::XLEN-1:0]              paddr_i,
    input  wire                                         dtlb_hit_i,
    // CSR file
    input  wire load_unit_pkg::approx_csr_t             approx_csr_i,
    // store buffer address check
    output logic [load_unit_pkg::PAGE_OFFSET_BITS-1:0]  page_offset_o,
    input  wire                                         page_offset_matches_i,
    // data cache
    output load_unit_pkg::dcache_req_t                  dcache_req_o,
    input  wire load_unit_pkg::dcache_rsp_t             dcache_rsp_i
);

    load_unit_pkg::load_info_t load_info;
    logic                      in_flush;
    logic                      kill;

    // request path
    load_issue_fsm u_issue (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .load_req_i            (load_req_i),
        .pop_ld_o              (pop_ld_o),
        .translation_req_o     (translation_req_o),
        .vaddr_o               (vaddr_o),
        .paddr_i               (paddr_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_o         (page_offset_o),
        .page_offset_matches_i (page_offset_matches_i),
        .approx_csr_i          (approx_csr_i),
        .dcache_req_o          (dcache_req_o),
        .dcache_rsp_i          (dcache_rsp_i),
        .load_info_o           (load_info),
        .in_flush_o            (in_flush),
        .kill_o                (kill)
    );

    // result path, combinational from the captured load and the response
    load_result_align u_align (
        .load_info_i  (load_info),
        .dcache_rsp_i (dcache_rsp_i),
        .in_flush_i   (in_flush),
        .kill_i       (kill),
        .valid_o      (valid_o),
        .trans_id_o   (trans_id_o),
        .result_o     (result_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_load_ref.svh */
/*
 * reference model for the load unit testbench
 * expected load results and approximate flags worked out from the
 * load rules, and the value comparison used by every check
 */
`ifndef TB_LOAD_REF_SVH
`define TB_LOAD_REF_SVH

    // number of bytes that an operator reads
    function automatic int access_bytes(input load_unit_pkg::load_op_e op);
        int nbytes;
        case (op)
            load_unit_pkg::LD:                     nbytes = 8;
            load_unit_pkg::LW, load_unit_pkg::LWU: nbytes = 4;
            load_unit_pkg::LH, load_unit_pkg::LHU: nbytes = 2;
            default:                               nbytes = 1;
        endcase
        return nbytes;
    endfunction

    // picks the loaded bytes one at a time out of the returned double word
    function automatic logic [63:0] expected_result(input load_unit_pkg::load_op_e op,
                                                    input logic [2:0] offset,
                                                    input logic [63:0] rdata);
        logic [63:0] value;
        int          nbytes;
        int          i;
        nbytes = access_bytes(op);
        value  = '0;
        for (i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = rdata[8*(offset + i) +: 8];
        end
        // signed forms copy the top loaded bit into every bit above it
        if ((op == load_unit_pkg::LW || op == load_unit_pkg::LH || op == load_unit_pkg::LB)
            && value[8*nbytes-1]) begin
            value = value | ~((64'd1 << (8 * nbytes)) - 64'd1);
        end
        return value;
    endfunction

    // inclusive window, only when the control value is hex A, never for address zero
    function automatic logic expected_approx(input logic [63:0] vaddr,
                                             input load_unit_pkg::approx_csr_t csr);
        if (csr.key != 64'hA || vaddr == '0) begin
            return 1'b0;
        end
        return (vaddr >= csr.base) && (vaddr <= csr.limit);
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

`endif

/* testbench/tb_load_unit.sv */
/*
 * testbench for the load unit
 * models the MMU, the store buffer check and the data cache around the DUT,
 * runs directed and random loads and compares every retired result
 * with the reference model
 */
`timescale 1ns/100ps
`default_nettype none

module tb_load_unit;

    localparam int NUM_LOADS    = 80;
    // store match, grant wait, TLB retry, tag cycle and return delay of the slowest load
    localparam int WORST_CYCLES = 24;

    typedef struct packed {
        logic [load_unit_pkg::TRANS_ID_BITS-1:0] trans_id;
        logic [load_unit_pkg::XLEN-1:0]          result;
    } expect_t;

    logic                        clk = 1'b0;
    logic                        rst_n = 1'b0;
    logic                        flush = 1'b0;
    logic                        valid = 1'b0;
    load_unit_pkg::load_req_t    load_req = '0;
    logic                        pop_ld;
    logic                        valid_out;
    logic [2:0]                  trans_id;
    logic [63:0]                 result;
    logic                        translation_req;
    logic [63:0]                 vaddr;
    logic [63:0]                 paddr = '0;
    logic                        dtlb_hit = 1'b0;
    load_unit_pkg::approx_csr_t  approx_csr = '0;
    logic [11:0]                 page_offset;
    logic                        page_offset_match = 1'b0;
    load_unit_pkg::dcache_req_t  dcache_req;
    load_unit_pkg::dcache_rsp_t  dcache_rsp;
    logic                        gnt = 1'b0;
    logic                        model_rvalid = 1'b0;
    logic                        stray_rvalid = 1'b0;
    logic [63:0]                 rdata = '0;
    logic [63:0]                 ret_data = '0;
    expect_t                     exp_q[$];
    logic [43:0]                 tag_q[$];
    int                          seed = 32'hb921;
    int                          error_count = 0;
    int                          check_count = 0;
    int                          test_count = 0;
    int                          load_count = 0;
    int                          rv_delay = 0;
    int                          ret_wait = 0;
    int                          tags_sent = 0;
    int                          words_returned = 0;
    logic                        last_gnt = 1'b0;
    logic                        last_hit = 1'b0;
    logic                        last_flush = 1'b0;

    `include "tb_load_ref.svh"

    assign dcache_rsp = '{gnt, model_rvalid | stray_rvalid, rdata};

    always #5 clk = ~clk;

    load_unit uut (
        .clk_i (clk), .rst_ni (rst_n), .flush_i (flush),
        .valid_i (valid), .load_req_i (load_req), .pop_ld_o (pop_ld),
        .valid_o (valid_out), .trans_id_o (trans_id), .result_o (result),
        .translation_req_o (translation_req), .vaddr_o (vaddr),
        .paddr_i (paddr), .dtlb_hit_i (dtlb_hit), .approx_csr_i (approx_csr),
        .page_offset_o (page_offset), .page_offset_matches_i (page_offset_match),
        .dcache_req_o (dcache_req), .dcache_rsp_i (dcache_rsp)
    );

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // the MMU flips a fixed pattern into the page number
    function automatic logic [63:0] translate(input logic [63:0] va);
        return {va[63:12] ^ 52'h5_A5A5_0000_1234, va[11:0]};
    endfunction

    // every bit of the aligned address feeds the memory word
    function automatic logic [63:0] mem_word(input logic [63:0] pa);
        logic [63:0] aligned;
        aligned = {pa[63:3], 3'b000};
        return (aligned * 64'h9E37_79B9_7F4A_7C15) ^ {aligned[31:0], aligned[63:32]};
    endfunction

    function automatic load_unit_pkg::load_req_t make_request(input load_unit_pkg::load_op_e op,
                                                              input int offset);
        load_unit_pkg::load_req_t req;
        req.trans_id     = load_count[2:0];
        req.vaddr[63:32] = $random(seed);
        req.vaddr[31:0]  = $random(seed);
        req.vaddr[2:0]   = offset[2:0];
        req.op           = op;
        req.be           = 8'($random(seed));
        load_count++;
        return req;
    endfunction

    // ------------------------------------------------------------------------
    // load driver that starts and returns on a falling edge
    // ------------------------------------------------------------------------
    task automatic run_load(input load_unit_pkg::load_req_t req, input int match_len,
                            input int gnt_wait, input bit miss);
        expect_t exp;
        int      cyc;
        int      hit_from;
        int      gnt_from;
        bit      accepted;
        cyc          = 0;
        accepted     = 1'b0;
        hit_from     = miss ? 1000 : 0;
        gnt_from     = match_len + gnt_wait;
        paddr        = translate(req.vaddr);
        exp.trans_id = req.trans_id;
        exp.result   = expected_result(req.op, req.vaddr[2:0], mem_word(paddr));
        exp_q.push_back(exp);
        tag_q.push_back(paddr[55:12]);
        rv_delay     = pick(4);
        load_req     = req;
        valid        = 1'b1;
        while (!accepted) begin
            page_offset_match = (cyc < match_len);
            dtlb_hit          = (cyc >= hit_from);
            gnt               = (cyc >= gnt_from);
            @(posedge clk);
            accepted = pop_ld;
            compare_value("vaddr_o", vaddr, req.vaddr);
            compare_value("page_offset_o", page_offset, req.vaddr[11:0]);
            compare_value("address_index", dcache_req.address_index, req.vaddr[11:0]);
            // the cache takes the access size as log2 of the byte count
            compare_value("data_size", dcache_req.data_size, $clog2(access_bytes(req.op)));
            compare_value("data_be", dcache_req.data_be, req.be);
            if (page_offset_match) begin
                compare_value("data_req", dcache_req.data_req, 1'b0);
            end
            // translation runs with each cache request and through the refill of a miss
            if (dcache_req.data_req || (miss && cyc + 1 >= hit_from && cyc <= hit_from)) begin
                compare_value("translation_req_o", translation_req, 1'b1);
            end
            // translation of a missed load completes three cycles after the grant
            if (dcache_req.data_req && gnt && !dtlb_hit) begin
                hit_from = cyc + 3;
                gnt_from = cyc + 4;
            end
            @(negedge clk);
            cyc++;
        end
        valid             = 1'b0;
        gnt               = 1'b0;
        page_offset_match = 1'b0;
        // with the queue empty the MMU sees no request
        while (exp_q.size() != 0) begin
            @(posedge clk);
            compare_value("translation_req_o", translation_req, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic probe_approx(input logic [63:0] addr);
        load_req.vaddr = addr;
        @(posedge clk);
        compare_value("approx", dcache_req.approx, expected_approx(addr, approx_csr));
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int first_error);
        test_count++;
        $display("test %-12s %0d errors", name, error_count - first_error);
    endtask

    // ------------------------------------------------------------------------
    // cache port monitor and cache model
    // ------------------------------------------------------------------------
    always @(posedge clk) begin : handshake_monitor
        if (rst_n) begin
            // the tag cycle follows every grant and, as a kill, every flush
            compare_value("tag_valid", dcache_req.tag_valid, last_gnt || last_flush);
            compare_value("kill_req", dcache_req.kill_req,
                          (last_gnt && !last_hit) || last_flush);
            compare_value("pop_ld_o", pop_ld, dcache_req.data_req && gnt && dtlb_hit);
            if (dcache_req.tag_valid && !dcache_req.kill_req) begin
                if (tag_q.size() == 0) begin
                    error_count++;
                    $display("tag sent with no load waiting for it at %0t", $time);
                end else begin
                    compare_value("address_tag", dcache_req.address_tag, tag_q.pop_front());
                end
                ret_data = mem_word(paddr);
                tags_sent++;
            end
        end
        last_gnt   = rst_n && dcache_req.data_req && gnt;
        last_hit   = dtlb_hit;
        last_flush = rst_n && flush;
    end

    // data returns in order rv_delay cycles after the tag
    always @(negedge clk) begin : cache_return
        model_rvalid = 1'b0;
        if (tags_sent != words_returned) begin
            if (ret_wait >= rv_delay) begin
                model_rvalid = 1'b1;
                rdata        = ret_data;
                ret_wait     = 0;
                words_returned++;
            end else begin
                ret_wait++;
            end
        end
    end

    always @(posedge clk) begin : compare_results
        expect_t exp;
        if (rst_n && valid_out) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("valid_o raised with no load outstanding at %0t", $time);
            end else begin
                exp = exp_q.pop_front();
                compare_value("trans_id_o", trans_id, exp.trans_id);
                compare_value("result_o", result, exp.result);
            end
        end
    end

    initial begin : watchdog
        #(NUM_LOADS * WORST_CYCLES * 10 + 5000);
        $display("timeout: the loads did not retire in time");
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    initial begin : main
        load_unit_pkg::load_op_e op;
        int first_error;
        int op_idx;
        int offset;
        int match_len;
        int gnt_wait;
        bit miss;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        first_error = error_count;
        for (op_idx = 0; op_idx < 7; op_idx++) begin
            op = load_unit_pkg::load_op_e'(op_idx);
            for (offset = 0; offset < 8; offset += access_bytes(op)) begin
                run_load(make_request(op, offset), 0, pick(3), 1'b0);
            end
        end
        report_test("operators", first_error);

        first_error = error_count;
        repeat (40) begin
            op        = load_unit_pkg::load_op_e'(pick(7));
            offset    = pick(8) & ~(access_bytes(op) - 1);
            match_len = (pick(4) == 0) ? pick(3) : 0;
            gnt_wait  = pick(5);
            miss      = (pick(5) == 0);
            run_load(make_request(op, offset), match_len, gnt_wait, miss);
        end
        report_test("random", first_error);

        first_error = error_count;
        run_load(make_request(load_unit_pkg::LW, 4), 4, 0, 1'b0);
        run_load(make_request(load_unit_pkg::LBU, 7), 3, 2, 1'b0);
        report_test("page_offset", first_error);

        first_error = error_count;
        run_load(make_request(load_unit_pkg::LH, 2), 0, 1, 1'b1);
        run_load(make_request(load_unit_pkg::LD, 0), 2, 0, 1'b1);
        report_test("tlb_miss", first_error);

        first_error = error_count;
        approx_csr = '{64'h0000_0040_0000_1000, 64'h0000_0040_0000_1FF8, 64'hA};
        probe_approx(64'h0000_0040_0000_0FFF);
        probe_approx(64'h0000_0040_0000_1100);
        probe_approx(64'h0000_0040_0000_1000);
        probe_approx(64'h0000_0040_0000_1FF8);
        probe_approx(64'h0000_0040_0000_1FF9);
        approx_csr.key = 64'h5;
        probe_approx(64'h0000_0040_0000_1100);
        approx_csr = '{64'h0, 64'h0000_0040_0000_1FF8, 64'hA};
        probe_approx(64'h0);
        report_test("approx", first_error);

        // a response in the kill cycle after a flush must not retire
        first_error = error_count;
        flush = 1'b1;
        @(negedge clk);
        flush        = 1'b0;
        stray_rvalid = 1'b1;
        @(posedge clk);
        compare_value("valid_o", valid_out, 1'b0);
        @(negedge clk);
        stray_rvalid = 1'b0;
        @(negedge clk);
        report_test("flush", first_error);

        $display("tests %0d  loads %0d  checks %0d  errors %0d",
                 test_count, load_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* load_unit.f */
+incdir+testbench
src/load_unit_pkg.sv
src/load_issue_fsm.sv
src/load_result_align.sv
src/load_unit.sv
testbench/tb_load_unit.sv

/* run_sim.sh */
#!/bin/sh
# builds the load unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f load_unit.f \
    --top-module tb_load_unit \
    -Mdir obj_dir \
    -o tb_load_unit

./obj_dir/tb_load_unit > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
